//--- sched_defs.svh
/*
 * Sizing macros for the ALU scheduler.
 * Include before any package or module that sizes a port or array.
 */
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// Queue depth
`define SCHED_ENTRIES 8

// Physical tag width, 32 registers
`define SCHED_TAG_W 5

// Dispatch sequence width, twice the queue depth for the wrap compare
`define SCHED_SEQ_W 4

`define SCHED_DATA_W 32

`endif

//--- alu_pkg.sv
/*
 * Instruction-side types: opcodes, execute operations, field positions.
 */
package alu_pkg;

  typedef enum logic [3:0] {
    OPC_NOP  = 4'h0,
    OPC_ADD  = 4'h1,
    OPC_SUB  = 4'h2,
    OPC_AND  = 4'h3,
    OPC_OR   = 4'h4,
    OPC_XOR  = 4'h5,
    OPC_SLL  = 4'h6,
    OPC_SRL  = 4'h7,
    OPC_ADDI = 4'h8
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL
  } alu_op_t;

  // Instruction word layout
  localparam int OPC_HI = 31;
  localparam int OPC_LO = 28;
  localparam int RD_HI  = 27;
  localparam int RD_LO  = 23;
  localparam int RS1_HI = 22;
  localparam int RS1_LO = 18;
  localparam int RS2_HI = 17;
  localparam int RS2_LO = 13;
  localparam int IMM_HI = 7;
  localparam int IMM_LO = 0;

endpackage

//--- sched_pkg.sv
/*
 * Scheduler types shared by the queue, its entries and the execute stage.
 */
`include "sched_defs.svh"

package sched_pkg;

  typedef logic [`SCHED_TAG_W-1:0] tag_t;
  typedef logic [`SCHED_SEQ_W-1:0] seq_t;

  typedef enum logic [1:0] {INIT, WAIT, ISSUED, CLEAR} sched_state_t;

  typedef struct packed {
    tag_t tag;
    logic valid;
    logic ready;
  } src_t;

  // One queued operation, 36 bits
  typedef struct packed {
    logic            valid;
    alu_pkg::alu_op_t op;
    tag_t            rd;
    src_t            rs1;
    src_t            rs2;
    logic [7:0]      imm;
    logic            use_imm;
    seq_t            seq;
  } entry_t;

  // True when seq is the flush point or younger, modulo the sequence space
  function automatic logic is_flushed(seq_t seq, seq_t flush_seq);
    seq_t diff;
    diff = seq - flush_seq;
    return diff < seq_t'(`SCHED_ENTRIES);
  endfunction

endpackage

//--- alu_decode.sv
/*
 * Combinational decode of a dispatched instruction word.
 * NOP and unknown opcodes raise o_is_nop so no queue slot is taken.
 */
`timescale 1ns/1ps

module alu_decode (
  input  logic [31:0]       i_instr,
  input  sched_pkg::seq_t   i_seq,
  output alu_pkg::alu_op_t  o_op,
  output sched_pkg::tag_t   o_rd,
  output sched_pkg::tag_t   o_rs1,
  output sched_pkg::tag_t   o_rs2,
  output logic              o_rs2_valid,
  output logic [7:0]        o_imm,
  output logic              o_use_imm,
  output logic              o_is_nop,
  output sched_pkg::seq_t   o_seq
);

  alu_pkg::opcode_t w_opc;

  assign w_opc  = alu_pkg::opcode_t'(i_instr[alu_pkg::OPC_HI:alu_pkg::OPC_LO]);
  assign o_rd   = i_instr[alu_pkg::RD_HI:alu_pkg::RD_LO];
  assign o_rs1  = i_instr[alu_pkg::RS1_HI:alu_pkg::RS1_LO];
  assign o_rs2  = i_instr[alu_pkg::RS2_HI:alu_pkg::RS2_LO];
  assign o_imm  = i_instr[alu_pkg::IMM_HI:alu_pkg::IMM_LO];
  assign o_seq  = i_seq;  // Travels with the decoded fields

  always_comb begin
    o_op        = alu_pkg::ALU_ADD;
    o_rs2_valid = 1'b1;
    o_use_imm   = 1'b0;
    o_is_nop    = 1'b0;
    case (w_opc)
      alu_pkg::OPC_ADD: o_op = alu_pkg::ALU_ADD;
      alu_pkg::OPC_SUB: o_op = alu_pkg::ALU_SUB;
      alu_pkg::OPC_AND: o_op = alu_pkg::ALU_AND;
      alu_pkg::OPC_OR:  o_op = alu_pkg::ALU_OR;
      alu_pkg::OPC_XOR: o_op = alu_pkg::ALU_XOR;
      alu_pkg::OPC_SLL: o_op = alu_pkg::ALU_SLL;
      alu_pkg::OPC_SRL: o_op = alu_pkg::ALU_SRL;
      alu_pkg::OPC_ADDI: begin
        o_rs2_valid = 1'b0;  // Second operand is the immediate
        o_use_imm   = 1'b1;
      end
      default: begin
        o_rs2_valid = 1'b0;
        o_is_nop    = 1'b1;
      end
    endcase
  end

endmodule

//--- issue_entry.sv
/*
 * A single scheduler slot. Holds one operation through INIT, WAIT,
 * ISSUED and CLEAR, wakes its sources on matching writebacks.
 */
`timescale 1ns/1ps

module issue_entry (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_put,
  input  sched_pkg::entry_t i_put_entry,
  input  logic              i_wb_valid,
  input  sched_pkg::tag_t   i_wb_tag,
  input  logic              i_picked,
  input  logic              i_flush,
  input  sched_pkg::seq_t   i_flush_seq,
  output logic              o_valid,
  output logic              o_ready,
  output sched_pkg::entry_t o_entry
);

  sched_pkg::sched_state_t r_state;
  sched_pkg::sched_state_t w_state_next;
  sched_pkg::entry_t       r_entry;
  sched_pkg::entry_t       w_entry_next;
  logic                    w_flush_hit;
  logic                    w_put_flush;

  function automatic logic wake_hit(sched_pkg::src_t src);
    return i_wb_valid & src.valid & (src.tag == i_wb_tag);
  endfunction

  assign w_flush_hit = i_flush & r_entry.valid &
                       sched_pkg::is_flushed(r_entry.seq, i_flush_seq);
  assign w_put_flush = i_flush & sched_pkg::is_flushed(i_put_entry.seq, i_flush_seq);

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    w_state_next = r_state;
    w_entry_next = r_entry;
    if (wake_hit(r_entry.rs1)) w_entry_next.rs1.ready = 1'b1;
    if (wake_hit(r_entry.rs2)) w_entry_next.rs2.ready = 1'b1;

    case (r_state)
      sched_pkg::INIT, sched_pkg::CLEAR: begin
        w_state_next       = sched_pkg::INIT;
        w_entry_next.valid = 1'b0;
        if (i_put) begin
          w_entry_next = i_put_entry;
          // Same-cycle broadcast would be missed by the scoreboard lookup
          if (wake_hit(i_put_entry.rs1)) w_entry_next.rs1.ready = 1'b1;
          if (wake_hit(i_put_entry.rs2)) w_entry_next.rs2.ready = 1'b1;
          if (w_put_flush) begin
            w_entry_next.valid = 1'b0;
            w_state_next       = sched_pkg::CLEAR;
          end else begin
            w_state_next = sched_pkg::WAIT;
          end
        end
      end
      sched_pkg::WAIT: begin
        if (w_flush_hit) begin
          w_entry_next.valid = 1'b0;
          w_state_next       = sched_pkg::CLEAR;
        end else if (i_picked) begin
          w_state_next = sched_pkg::ISSUED;
        end
      end
      sched_pkg::ISSUED: begin
        w_entry_next.valid = 1'b0;  // Execute handles any kill from here
        w_state_next       = sched_pkg::CLEAR;
      end
      default: w_state_next = sched_pkg::INIT;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= sched_pkg::INIT;
      r_entry <= '0;
    end else begin
      r_state <= w_state_next;
      r_entry <= w_entry_next;
    end
  end

  assign o_valid = r_entry.valid;
  assign o_ready = r_entry.valid & (r_state == sched_pkg::WAIT) & !w_flush_hit &
                   (!r_entry.rs1.valid | r_entry.rs1.ready) &
                   (!r_entry.rs2.valid | r_entry.rs2.ready);
  assign o_entry = r_entry;

  // Picker must only grant what this slot advertised
  a_pick_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_picked |-> o_ready);

endmodule

//--- issue_queue.sv
/*
 * Eight-slot issue queue. Allocates the lowest free slot on dispatch
 * and grants the lowest-index ready slot each cycle (not oldest first).
 */
`timescale 1ns/1ps
`include "sched_defs.svh"

module issue_queue (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_disp_valid,
  input  alu_pkg::alu_op_t  i_op,
  input  sched_pkg::tag_t   i_rd,
  input  sched_pkg::tag_t   i_rs1,
  input  sched_pkg::tag_t   i_rs2,
  input  logic              i_rs2_valid,
  input  logic [7:0]        i_imm,
  input  logic              i_use_imm,
  input  logic              i_is_nop,
  input  sched_pkg::seq_t   i_seq,
  input  logic              i_rs1_rdy,
  input  logic              i_rs2_rdy,
  input  logic              i_wb_valid,
  input  sched_pkg::tag_t   i_wb_tag,
  input  logic              i_flush,
  input  sched_pkg::seq_t   i_flush_seq,
  output logic              o_disp_ready,
  output logic              o_alloc_valid,
  output sched_pkg::tag_t   o_rs1_tag,
  output sched_pkg::tag_t   o_rs2_tag,
  output logic              o_grant_valid,
  output sched_pkg::entry_t o_grant
);

  localparam int N     = `SCHED_ENTRIES;
  localparam int IDX_W = $clog2(N);
  localparam int CNT_W = $clog2(N) + 1;

  logic [N-1:0]      w_valid;
  logic [N-1:0]      w_ready;
  logic [N-1:0]      w_picked;
  sched_pkg::entry_t w_entry [N];
  sched_pkg::entry_t w_put_entry;
  logic [IDX_W-1:0]  w_alloc_idx;
  logic [IDX_W-1:0]  w_pick_idx;
  logic [CNT_W-1:0]  w_count;
  logic              w_accept;

  assign o_rs1_tag = i_rs1;  // Scoreboard lookup at dispatch
  assign o_rs2_tag = i_rs2;

  always_comb begin
    w_put_entry           = '0;
    w_put_entry.valid     = 1'b1;
    w_put_entry.op        = i_op;
    w_put_entry.rd        = i_rd;
    w_put_entry.rs1       = '{tag: i_rs1, valid: 1'b1, ready: i_rs1_rdy};
    w_put_entry.rs2       = '{tag: i_rs2, valid: i_rs2_valid, ready: i_rs2_rdy | !i_rs2_valid};
    w_put_entry.imm       = i_imm;
    w_put_entry.use_imm   = i_use_imm;
    w_put_entry.seq       = i_seq;
  end

  // Occupancy, lowest free slot, lowest ready slot
  always_comb begin
    w_count     = '0;
    w_alloc_idx = '0;
    w_pick_idx  = '0;
    for (int i = N - 1; i >= 0; i--) begin
      w_count = w_count + CNT_W'(w_valid[i]);
      if (!w_valid[i]) w_alloc_idx = IDX_W'(i);
      if (w_ready[i])  w_pick_idx  = IDX_W'(i);
    end
  end

  assign o_disp_ready  = (w_count < CNT_W'(N));
  assign w_accept      = i_disp_valid & o_disp_ready & !i_is_nop;
  assign o_alloc_valid = w_accept;
  assign o_grant_valid = |w_ready;
  assign o_grant       = w_entry[w_pick_idx];

  for (genvar g = 0; g < N; g++) begin : g_entry
    assign w_picked[g] = o_grant_valid & (w_pick_idx == IDX_W'(g));

    issue_entry u_entry (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_put       (w_accept & (w_alloc_idx == IDX_W'(g))),
      .i_put_entry (w_put_entry),
      .i_wb_valid  (i_wb_valid),
      .i_wb_tag    (i_wb_tag),
      .i_picked    (w_picked[g]),
      .i_flush     (i_flush),
      .i_flush_seq (i_flush_seq),
      .o_valid     (w_valid[g]),
      .o_ready     (w_ready[g]),
      .o_entry     (w_entry[g])
    );
  end

  // Pick is exactly the lowest set ready bit and never more than one slot
  a_one_pick: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_picked == (w_ready & (~w_ready + N'(1))));

endmodule

//--- alu_execute.sv
/*
 * Single-stage ALU. Operands are read in the grant cycle and the result
 * is registered at its end. Flush kills both the grant and the held result.
 */
`timescale 1ns/1ps
`include "sched_defs.svh"

module alu_execute (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_grant_valid,
  input  sched_pkg::entry_t        i_grant,
  input  logic [`SCHED_DATA_W-1:0] i_rs1_data,
  input  logic [`SCHED_DATA_W-1:0] i_rs2_data,
  input  logic                     i_flush,
  input  sched_pkg::seq_t          i_flush_seq,
  output sched_pkg::tag_t          o_rd_tag1,
  output sched_pkg::tag_t          o_rd_tag2,
  output logic                     o_ex_valid,
  output sched_pkg::tag_t          o_ex_tag,
  output logic [`SCHED_DATA_W-1:0] o_ex_data
);

  localparam int DATA_W = `SCHED_DATA_W;

  logic              r_valid;
  sched_pkg::seq_t   r_seq;
  logic [DATA_W-1:0] w_b;
  logic [DATA_W-1:0] w_res;

  assign o_rd_tag1 = i_grant.rs1.tag;
  assign o_rd_tag2 = i_grant.rs2.tag;
  assign w_b = i_grant.use_imm ? DATA_W'(i_grant.imm) : i_rs2_data;  // Zero-extended imm

  always_comb begin
    case (i_grant.op)
      alu_pkg::ALU_SUB: w_res = i_rs1_data - w_b;
      alu_pkg::ALU_AND: w_res = i_rs1_data & w_b;
      alu_pkg::ALU_OR:  w_res = i_rs1_data | w_b;
      alu_pkg::ALU_XOR: w_res = i_rs1_data ^ w_b;
      alu_pkg::ALU_SLL: w_res = i_rs1_data << w_b[4:0];
      alu_pkg::ALU_SRL: w_res = i_rs1_data >> w_b[4:0];
      default:          w_res = i_rs1_data + w_b;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_grant_valid &
                 !(i_flush & sched_pkg::is_flushed(i_grant.seq, i_flush_seq));
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex_tag  <= i_grant.rd;
    o_ex_data <= w_res;
    r_seq     <= i_grant.seq;
  end

  // Held result dies if a flush lands while it waits for the result stage
  assign o_ex_valid = r_valid & !(i_flush & sched_pkg::is_flushed(r_seq, i_flush_seq));

endmodule

//--- alu_result.sv
/*
 * Physical register file with ready scoreboard. Writes the execute result,
 * sets its ready bit and broadcasts the tag one cycle later.
 */
`timescale 1ns/1ps
`include "sched_defs.svh"

module alu_result (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_alloc_valid,
  input  sched_pkg::tag_t          i_alloc_tag,
  input  sched_pkg::tag_t          i_rs1_tag,
  input  sched_pkg::tag_t          i_rs2_tag,
  output logic                     o_rs1_rdy,
  output logic                     o_rs2_rdy,
  input  sched_pkg::tag_t          i_rd_tag1,
  input  sched_pkg::tag_t          i_rd_tag2,
  output logic [`SCHED_DATA_W-1:0] o_rd_data1,
  output logic [`SCHED_DATA_W-1:0] o_rd_data2,
  input  logic                     i_ex_valid,
  input  sched_pkg::tag_t          i_ex_tag,
  input  logic [`SCHED_DATA_W-1:0] i_ex_data,
  output logic                     o_wb_valid,
  output sched_pkg::tag_t          o_wb_tag,
  output logic [`SCHED_DATA_W-1:0] o_wb_data
);

  localparam int DATA_W   = `SCHED_DATA_W;
  localparam int NUM_REGS = 1 << `SCHED_TAG_W;

  logic [DATA_W-1:0]   r_regs [NUM_REGS];
  logic [NUM_REGS-1:0] r_rdy;

  assign o_rs1_rdy  = r_rdy[i_rs1_tag];
  assign o_rs2_rdy  = r_rdy[i_rs2_tag];
  assign o_rd_data1 = r_regs[i_rd_tag1];
  assign o_rd_data2 = r_regs[i_rd_tag2];

  // Register i starts holding i
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        r_regs[i] <= DATA_W'(i);
      end
      r_rdy      <= '1;
      o_wb_valid <= 1'b0;
    end else begin
      if (i_alloc_valid) r_rdy[i_alloc_tag] <= 1'b0;  // Pending until written back
      if (i_ex_valid) begin
        r_regs[i_ex_tag] <= i_ex_data;
        r_rdy[i_ex_tag]  <= 1'b1;
      end
      o_wb_valid <= i_ex_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_wb_tag  <= i_ex_tag;
    o_wb_data <= i_ex_data;
  end

  // Each tag is allocated before its single writeback
  a_wb_pending: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex_valid |-> !r_rdy[i_ex_tag]);

endmodule

//--- alu_sched_top.sv
/*
 * ALU scheduling subsystem: decode, issue queue, execute and result.
 */
`timescale 1ns/1ps
`include "sched_defs.svh"

module alu_sched_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_disp_valid,
  input  logic [31:0]              i_disp_instr,
  input  sched_pkg::seq_t          i_disp_seq,
  input  logic                     i_flush,
  input  sched_pkg::seq_t          i_flush_seq,
  output logic                     o_disp_ready,
  output logic                     o_wb_valid,
  output sched_pkg::tag_t          o_wb_tag,
  output logic [`SCHED_DATA_W-1:0] o_wb_data
);

  alu_pkg::alu_op_t        dec_op;
  sched_pkg::tag_t         dec_rd, dec_rs1, dec_rs2;
  sched_pkg::seq_t         dec_seq;
  logic                    dec_rs2_valid, dec_use_imm, dec_is_nop;
  logic [7:0]              dec_imm;
  logic                    alloc_valid, rs1_rdy, rs2_rdy;
  sched_pkg::tag_t         lk_tag1, lk_tag2, rd_tag1, rd_tag2, ex_tag;
  logic                    grant_valid, ex_valid;
  sched_pkg::entry_t       grant;
  logic [`SCHED_DATA_W-1:0] rd_data1, rd_data2, ex_data;

  alu_decode u_decode (
    .i_instr (i_disp_instr), .i_seq (i_disp_seq), .o_op (dec_op), .o_rd (dec_rd),
    .o_rs1 (dec_rs1), .o_rs2 (dec_rs2), .o_rs2_valid (dec_rs2_valid), .o_imm (dec_imm),
    .o_use_imm (dec_use_imm), .o_is_nop (dec_is_nop), .o_seq (dec_seq));

  issue_queue u_queue (
    .i_clk (i_clk), .i_reset_n (i_reset_n), .i_disp_valid (i_disp_valid),
    .i_op (dec_op), .i_rd (dec_rd), .i_rs1 (dec_rs1), .i_rs2 (dec_rs2),
    .i_rs2_valid (dec_rs2_valid), .i_imm (dec_imm), .i_use_imm (dec_use_imm),
    .i_is_nop (dec_is_nop), .i_seq (dec_seq), .i_rs1_rdy (rs1_rdy), .i_rs2_rdy (rs2_rdy),
    .i_wb_valid (o_wb_valid), .i_wb_tag (o_wb_tag), .i_flush (i_flush),
    .i_flush_seq (i_flush_seq), .o_disp_ready (o_disp_ready), .o_alloc_valid (alloc_valid),
    .o_rs1_tag (lk_tag1), .o_rs2_tag (lk_tag2), .o_grant_valid (grant_valid),
    .o_grant (grant));

  alu_execute u_execute (
    .i_clk (i_clk), .i_reset_n (i_reset_n), .i_grant_valid (grant_valid), .i_grant (grant),
    .i_rs1_data (rd_data1), .i_rs2_data (rd_data2), .i_flush (i_flush),
    .i_flush_seq (i_flush_seq), .o_rd_tag1 (rd_tag1), .o_rd_tag2 (rd_tag2),
    .o_ex_valid (ex_valid), .o_ex_tag (ex_tag), .o_ex_data (ex_data));

  alu_result u_result (
    .i_clk (i_clk), .i_reset_n (i_reset_n), .i_alloc_valid (alloc_valid),
    .i_alloc_tag (dec_rd), .i_rs1_tag (lk_tag1), .i_rs2_tag (lk_tag2),
    .o_rs1_rdy (rs1_rdy), .o_rs2_rdy (rs2_rdy), .i_rd_tag1 (rd_tag1), .i_rd_tag2 (rd_tag2),
    .o_rd_data1 (rd_data1), .o_rd_data2 (rd_data2), .i_ex_valid (ex_valid),
    .i_ex_tag (ex_tag), .i_ex_data (ex_data), .o_wb_valid (o_wb_valid),
    .o_wb_tag (o_wb_tag), .o_wb_data (o_wb_data));

endmodule

//--- tb_alu_sched.sv
/*
 * Testbench for alu_sched_top. Dispatches and flushes from alu_stim.txt,
 * collects writebacks per tag and checks them at the end of each test.
 */
`timescale 1ns/1ps
`include "sched_defs.svh"

module tb_alu_sched;

  localparam int PERIOD  = 100;
  localparam int MAX_REC = 128;
  localparam int SETTLE  = 8;  // Cycles before checking absent writebacks

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_disp_valid;
  logic [31:0]              i_disp_instr;
  sched_pkg::seq_t          i_disp_seq;
  logic                     i_flush;
  sched_pkg::seq_t          i_flush_seq;
  logic                     o_disp_ready;
  logic                     o_wb_valid;
  sched_pkg::tag_t          o_wb_tag;
  logic [`SCHED_DATA_W-1:0] o_wb_data;

  int          rec_kind [MAX_REC];
  logic [31:0] rec_a [MAX_REC];
  logic [31:0] rec_b [MAX_REC];
  logic [31:0] rec_c [MAX_REC];
  int          num_rec;

  bit          wb_seen [32];
  logic [31:0] wb_val [32];
  logic [4:0]  exp_tag [$];
  logic [31:0] exp_val [$];
  logic [4:0]  none_tag [$];

  int wb_total;
  int n_expect;
  int errors;
  int test_errors;
  int test_id;
  int tests_run;
  int tests_failed;
  int cycles;
  int limit;
  int gap_on;
  int stall_seen;
  int rnd;

  alu_sched_top u_alu_sched_top (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_disp_instr (i_disp_instr),
    .i_disp_seq   (i_disp_seq),
    .i_flush      (i_flush),
    .i_flush_seq  (i_flush_seq),
    .o_disp_ready (o_disp_ready),
    .o_wb_valid   (o_wb_valid),
    .o_wb_tag     (o_wb_tag),
    .o_wb_data    (o_wb_data)
  );

  initial i_clk = 1'b0;
  always #(PERIOD / 2) i_clk = ~i_clk;

  // --------------------------------------------------
  // Writeback monitor and run limit
  // --------------------------------------------------
  always @(posedge i_clk) begin
    if (i_reset_n && o_wb_valid) begin
      if (wb_seen[o_wb_tag]) begin
        $display("tag %0d written back twice in test %0d", o_wb_tag, test_id);
        errors++;
        test_errors++;
      end
      wb_seen[o_wb_tag] = 1'b1;
      wb_val[o_wb_tag]  = o_wb_data;
      wb_total++;
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run exceeded %0d cycles", limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic error(string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  // One record per non-comment line
  task automatic read_stim();
    int    fd;
    int    n;
    int    k;
    string line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    num_rec = 0;
    fd = $fopen("alu_stim.txt", "r");
    if (fd == 0) begin
      error("cannot open alu_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          a = '0;
          b = '0;
          c = '0;
          n = $sscanf(line, "%c %h %h %h", k, a, b, c);
          rec_kind[num_rec] = k;
          rec_a[num_rec]    = a;
          rec_b[num_rec]    = b;
          rec_c[num_rec]    = c;
          num_rec++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Valid is held until the queue has room
  task automatic dispatch(logic [31:0] instr, logic [31:0] seq, bit has_exp,
                          logic [31:0] val);
    int idle;
    if (gap_on != 0) begin
      idle = $urandom % 4;
      repeat (idle) begin
        @(posedge i_clk);
        #5;
      end
    end
    i_disp_valid = 1'b1;
    i_disp_instr = instr;
    i_disp_seq   = seq[`SCHED_SEQ_W-1:0];
    while (!o_disp_ready) begin
      stall_seen = 1;
      @(posedge i_clk);
      #5;
    end
    @(posedge i_clk);
    #5;
    i_disp_valid = 1'b0;
    if (has_exp) begin
      exp_tag.push_back(instr[alu_pkg::RD_HI:alu_pkg::RD_LO]);
      exp_val.push_back(val);
      n_expect++;
    end else begin
      none_tag.push_back(instr[alu_pkg::RD_HI:alu_pkg::RD_LO]);
    end
  endtask

  task automatic pulse_flush(logic [31:0] seq);
    i_flush     = 1'b1;
    i_flush_seq = seq[`SCHED_SEQ_W-1:0];
    @(posedge i_clk);
    #5;
    i_flush = 1'b0;
  endtask

  task automatic start_test(int n);
    test_id     = n;
    test_errors = 0;
    stall_seen  = 0;
    for (int i = 0; i < 32; i++) begin
      wb_seen[i] = 1'b0;
    end
  endtask

  task automatic finish_test();
    foreach (exp_tag[i]) begin
      while (!wb_seen[exp_tag[i]]) @(negedge i_clk);
      if (wb_val[exp_tag[i]] !== exp_val[i]) begin
        error($sformatf("mismatch o_wb_data tag 0x%02h: got 0x%08h expected 0x%08h",
                        exp_tag[i], wb_val[exp_tag[i]], exp_val[i]));
      end
    end
    repeat (SETTLE) @(posedge i_clk);
    #5;
    foreach (none_tag[i]) begin
      if (wb_seen[none_tag[i]]) begin
        error($sformatf("tag %0d was written back although its op was flushed or a NOP",
                        none_tag[i]));
      end
    end
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d passed", test_id);
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d errors", test_id, test_errors);
    end
    exp_tag.delete();
    exp_val.delete();
    none_tag.delete();
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    i_reset_n    = 1'b0;
    i_disp_valid = 1'b0;
    i_disp_instr = '0;
    i_disp_seq   = '0;
    i_flush      = 1'b0;
    i_flush_seq  = '0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    wb_total     = 0;
    n_expect     = 0;
    cycles       = 0;
    limit        = 0;
    gap_on       = 1;
    stall_seen   = 0;
    test_id      = 0;
    rnd = $urandom(34);
    read_stim();
    limit = 40 * num_rec + 10;
    repeat (5) @(posedge i_clk);
    #5;
    i_reset_n = 1'b1;
    for (int r = 0; r < num_rec; r++) begin
      case (rec_kind[r])
        "T": start_test(rec_a[r]);
        "G": gap_on = rec_a[r];
        "D": dispatch(rec_a[r], rec_b[r], 1'b1, rec_c[r]);
        "N": dispatch(rec_a[r], rec_b[r], 1'b0, '0);
        "F": pulse_flush(rec_a[r]);
        "S": if (stall_seen == 0) error("queue never filled: o_disp_ready stayed high");
        "C": finish_test();
        default: error($sformatf("unknown stimulus record %0d", r));
      endcase
    end
    if (wb_total != n_expect) begin
      error($sformatf("mismatch writeback count: got 0x%0h expected 0x%0h",
                      wb_total, n_expect));
    end
    $display("tests %0d, failed %0d, writebacks %0d, errors %0d",
             tests_run, tests_failed, wb_total, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
alu_pkg.sv
sched_pkg.sv
alu_decode.sv
issue_entry.sv
issue_queue.sv
alu_execute.sv
alu_result.sv
alu_sched_top.sv
tb_alu_sched.sv

//--- run.sh
#!/bin/sh
# Build and run the ALU scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_alu_sched -Mdir obj_dir -o sim_alu_sched > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_alu_sched > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
exit 0

//--- alu_stim.txt
# Records, all numbers hex. T n starts a test, C ends it. G 0/1 turns idle gaps off/on.
# D instr seq value expects value on rd (instr[27:23]). N instr seq expects no writeback.
# F seq flushes at seq and younger. S requires that dispatch stalled on a full queue.
T 1
D 14146000 0 00000008
D 248ca000 1 fffffffe
D 35186000 2 00000002
D 45946000 3 00000007
D 56186000 4 00000005
D 669c6000 5 00000038
D 77182000 6 00000003
D 879c00f0 7 000000f7
C
T 2
D 181ce000 8 0000000e
D 88c00010 9 0000001e
D 69442000 a 0000003c
D 29c8c000 b 00000036
C
G 0
T 3
D 1a042000 c 00000002
D 1ad02000 d 00000003
D 1b542000 e 00000004
D 1bd82000 f 00000005
D 8c5c0001 0 00000006
D 8cdc0002 1 00000007
D 8d5c0003 2 00000008
D 8ddc0004 3 00000009
D 8e5c0005 4 0000000a
D 8edc0006 5 0000000b
D 8f5c0007 6 0000000c
D 8fdc0008 7 0000000d
S
C
T 4
D 18632000 8 0000000d
D 88c00001 9 0000000e
N 19462000 a
N 89c80001 b
F a
C
G 1
T 5
D 1a422000 a 0000001b
D 2ad02000 b 0000001a
D 5b54c000 c 0000001c
C
T 6
N 0f800000 d
D 8bd80004 e 00000020
C
